//--- correlator.f
hw/corr_cfg_pkg.sv
hw/corr_types_pkg.sv
hw/slot_sequencer.sv
hw/pair_sampler.sv
hw/visibility_accum.sv
hw/vis_bus_port.sv
hw/correlator_top.sv
tb/tb_correlator_sva.sv
tb/tb_correlator.sv

//--- Makefile
TOP       ?= tb_correlator
FLIST     ?= correlator.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP FLIST VERILATOR OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_correlator.sv
`default_nettype none

module tb_correlator;

   // ----------------------------------------
   // run length and watchdog limit
   // ----------------------------------------
   localparam int RESET_CYCLES = 10;
   // 5 + 3 + 2 + 3 + 4 passes over the whole run
   localparam int PASSES       = 17;
   // reset probe, six full readouts, six writes
   localparam int ACCESSES     = 2 + 6 * 2 * corr_cfg_pkg::NUM_SLOTS + 6;
   // gaps at most double a pass, each bus access takes three cycles
   localparam int LIMIT        = RESET_CYCLES + PASSES * corr_cfg_pkg::NUM_SLOTS * 2
                                 + ACCESSES * 3 + 200;
   localparam int HIST_MAX     = 64;

   // one enabled sample as the model records it
   typedef struct packed {
      logic [corr_cfg_pkg::SLOT_W-1:0]  slot;
      logic [corr_cfg_pkg::NUM_ANT-1:0] re;
      logic [corr_cfg_pkg::NUM_ANT-1:0] im;
   } sample_t;

   logic                                 clk_x;
   logic                                 rst;
   logic                                 en;
   logic                                 sw;
   logic [corr_cfg_pkg::NUM_ANT-1:0]     re;
   logic [corr_cfg_pkg::NUM_ANT-1:0]     im;
   logic                                 cyc;
   logic                                 stb;
   logic                                 we;
   logic [corr_cfg_pkg::BUS_ADR_W-1:0]   adr;
   logic [corr_cfg_pkg::ACC_W-1:0]       wdat;
   logic                                 ack;
   logic [corr_cfg_pkg::ACC_W-1:0]       rdat;

   // model of slot, bank and pending switch, plus samples per bank
   logic [31:0] lfsr;
   int          m_slot;
   logic        m_bank;
   logic        m_pend;
   sample_t     hist [2][HIST_MAX];
   int          hist_n [2];

   int          err_cnt;
   int          check_cnt;
   // readout handshake between stimulus and compare process
   int          req_seq;
   int          done_seq;
   int          req_mode;
   string       test_name;

   correlator_top dut (
      .clk_x (clk_x),
      .rst   (rst),
      .en_i  (en),
      .sw_i  (sw),
      .re_i  (re),
      .im_i  (im),
      .cyc_i (cyc),
      .stb_i (stb),
      .we_i  (we),
      .adr_i (adr),
      .dat_i (wdat),
      .ack_o (ack),
      .dat_o (rdat)
   );

   initial begin
      clk_x = 1'b0;
      forever #2 clk_x = ~clk_x;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   // x^32 + x^22 + x^2 + x + 1, one step per bit
   task automatic take_bits(input int n, output logic [31:0] v);
      logic fb;
      int   i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
   endtask

   // count of sign agreements for one slot over the recorded samples
   function automatic logic [31:0] ref_count(input logic bank, input int slot,
                                             input logic want_sin);
      logic [31:0]         cnt;
      corr_cfg_pkg::pair_t p;
      sample_t             smp;
      logic                ar;
      int                  i;
      cnt = '0;
      p   = corr_cfg_pkg::PAIR_TABLE[slot];
      for (i = 0; i < hist_n[bank]; i++) begin
         smp = hist[bank][i];
         ar  = smp.re[p.a];
         if (smp.slot == 4'(slot)) begin
            if (want_sin ? (ar == smp.im[p.b]) : (ar == smp.re[p.b])) begin
               cnt = cnt + 32'd1;
            end
         end
      end
      return cnt;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("ERR %s expected %0d actual %0d", name, exp, act);
      end
   endtask

   // drive one cycle, then advance the model as the next rising edge will
   task automatic drive_sample(input logic sample_en, input logic sample_sw);
      logic [31:0] r;
      logic [31:0] i;
      sample_t     s;
      take_bits(24, r);
      take_bits(24, i);
      @(negedge clk_x);
      en = sample_en;
      sw = sample_sw;
      re = r[23:0];
      im = i[23:0];
      if (sample_en) begin
         s.slot = 4'(m_slot);
         s.re   = r[23:0];
         s.im   = i[23:0];
         hist[m_bank][hist_n[m_bank]] = s;
         hist_n[m_bank] = hist_n[m_bank] + 1;
         if (m_slot == corr_cfg_pkg::NUM_SLOTS - 1) begin
            // pass boundary, new bank starts from zero
            if (m_pend || sample_sw) begin
               m_bank         = ~m_bank;
               m_pend         = 1'b0;
               hist_n[m_bank] = 0;
            end
            m_slot = 0;
         end else begin
            m_pend = m_pend | sample_sw;
            m_slot = m_slot + 1;
         end
      end else begin
         m_pend = m_pend | sample_sw;
      end
   endtask

   task automatic run_samples(input int n, input logic sw_last, input logic gaps);
      logic [31:0] g;
      int          k;
      for (k = 0; k < n; k++) begin
         take_bits(2, g);
         // one in four samples preceded by an idle cycle
         if (gaps && g[1:0] == 2'b00) begin
            drive_sample(1'b0, 1'b0);
         end
         drive_sample(1'b1, sw_last && (k == n - 1));
      end
      // let the last writes reach memory before a readout
      repeat (3) drive_sample(1'b0, 1'b0);
   endtask

   task automatic bus_access(input string test, input logic write,
                             input logic [4:0] a, output logic [31:0] rdata);
      int lat;
      @(negedge clk_x);
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = write;
      adr  = a;
      wdat = 32'hc0de_0000 | 32'(a);
      @(negedge clk_x);
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      lat = 1;
      while (!ack && lat < 4) begin
         @(negedge clk_x);
         lat++;
      end
      rdata = rdat;
      if (!ack) begin
         err_cnt++;
         $display("%s: bus request to address %0d was never acknowledged", test, a);
      end else begin
         check({test, " ack latency"}, 32'd1, 32'(lat));
         @(negedge clk_x);
         if (ack) begin
            err_cnt++;
            $display("%s: ack stayed high for more than one cycle", test);
         end
      end
   endtask

   // all 24 words of the inactive bank against the model
   task automatic read_all(input string test);
      logic [31:0] d;
      logic        rb;
      int          s;
      int          h;
      rb = ~m_bank;
      for (s = 0; s < corr_cfg_pkg::NUM_SLOTS; s++) begin
         for (h = 0; h < 2; h++) begin
            bus_access(test, 1'b0, {h[0], s[3:0]}, d);
            check($sformatf("%s slot %0d %s", test, s, (h == 1) ? "sin" : "cos"),
                  ref_count(rb, s, h == 1), d);
         end
      end
   endtask

   task automatic readout(input string name, input int mode);
      test_name = name;
      req_mode  = mode;
      req_seq   = req_seq + 1;
      wait (done_seq == req_seq);
   endtask

   // ----------------------------------------
   // compare process, owns the bus
   // ----------------------------------------
   initial begin : compare_proc
      logic [31:0] d;
      int          k;
      cyc  = 1'b0;
      stb  = 1'b0;
      we   = 1'b0;
      adr  = '0;
      wdat = '0;
      forever begin
         wait (req_seq != done_seq);
         if (req_mode == 0) begin
            check({test_name, " ack idle"}, 32'd0, {31'd0, ack});
            bus_access(test_name, 1'b0, 5'd0, d);
            bus_access(test_name, 1'b1, 5'd17, d);
         end else begin
            // writes land in both halves and must change nothing
            if (req_mode == 2) begin
               for (k = 0; k < 6; k++) begin
                  bus_access(test_name, 1'b1, 5'(k * 5), d);
               end
            end
            read_all(test_name);
         end
         done_seq = done_seq + 1;
      end
   end

   // ----------------------------------------
   // stimulus and verdict
   // ----------------------------------------
   initial begin : stimulus
      rst    = 1'b1;
      en     = 1'b0;
      sw     = 1'b0;
      re     = '0;
      im     = '0;
      lfsr   = 32'h13aa_bacb;
      m_slot = 0;
      m_bank = 1'b0;
      m_pend = 1'b0;
      hist_n[0] = 0;
      hist_n[1] = 0;
      repeat (RESET_CYCLES) @(posedge clk_x);
      @(negedge clk_x);
      rst = 1'b0;
      readout("reset", 0);
      // 60 samples into bank 0, switch on the last one
      run_samples(60, 1'b1, 1'b0);
      readout("integration", 1);
      // bank 1 fresh, then bank 0 again without its first interval
      run_samples(36, 1'b1, 1'b0);
      readout("clear_bank1", 1);
      run_samples(24, 1'b1, 1'b0);
      readout("clear_bank0", 1);
      // request at slot 5, rest of the pass stays in bank 1
      run_samples(29, 1'b0, 1'b0);
      drive_sample(1'b1, 1'b1);
      run_samples(6, 1'b0, 1'b0);
      readout("deferred", 1);
      // idle cycles, one of them carrying the switch request
      run_samples(30, 1'b0, 1'b1);
      drive_sample(1'b0, 1'b1);
      run_samples(18, 1'b0, 1'b1);
      readout("gaps", 1);
      readout("writes", 2);
      @(negedge clk_x);
      $display("checks %0d, errors %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (LIMIT) @(posedge clk_x);
      $display("watchdog: run did not finish within %0d cycles", LIMIT);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/tb_correlator_sva.sv
`default_nettype none

module corr_sva (
   input  wire logic                  clk_x,
   input  wire logic                  rst,
   input  wire logic                  cyc_i,
   input  wire logic                  stb_i,
   input  wire logic                  ack_i,
   input  wire logic                  en_i,
   // bank being integrated
   input  wire logic                  bank_i,
   input  wire corr_types_pkg::slot_t slot_i
);

   logic req;
   // enabled edge that consumes slot 11
   logic pass_end;

   assign req      = cyc_i && stb_i;
   assign pass_end = en_i && (slot_i.index == corr_cfg_pkg::LAST_SLOT);

   // ----------------------------------------
   // bus acknowledge
   // ----------------------------------------
   ack_after_req: assert property (@(posedge clk_x) disable iff (rst) req |=> ack_i)
      else $error("no ack one cycle after a bus request");

   ack_only_after_req: assert property (@(posedge clk_x) disable iff (rst) !req |=> !ack_i)
      else $error("ack without a bus request in the cycle before");

   ack_low_after_reset: assert property (@(posedge clk_x) rst |=> !ack_i)
      else $error("ack high right after a reset edge");

   // ----------------------------------------
   // bank switch only at the pass boundary
   // ----------------------------------------
   bank_at_pass_end: assert property (@(posedge clk_x) disable iff (rst)
      !pass_end |=> $stable(bank_i))
      else $error("active bank changed away from an enabled slot 11 edge");

endmodule

bind correlator_top corr_sva u_sva (
   .clk_x  (clk_x),
   .rst    (rst),
   .cyc_i  (cyc_i),
   .stb_i  (stb_i),
   .ack_i  (ack_o),
   .en_i   (en_i),
   .bank_i (active_bank),
   .slot_i (slot)
);

`default_nettype wire

//--- hw/correlator_top.sv
`default_nettype none

module correlator_top (
   input  wire logic                                  clk_x,
   input  wire logic                                  rst,
   // antenna side
   input  wire logic                                  en_i,
   input  wire logic                                  sw_i,
   input  wire logic [corr_cfg_pkg::NUM_ANT-1:0]      re_i,
   input  wire logic [corr_cfg_pkg::NUM_ANT-1:0]      im_i,
   // visibility readout bus
   input  wire logic                                  cyc_i,
   input  wire logic                                  stb_i,
   input  wire logic                                  we_i,
   input  wire logic [corr_cfg_pkg::BUS_ADR_W-1:0]    adr_i,
   input  wire logic [corr_cfg_pkg::ACC_W-1:0]        dat_i,
   output logic                                       ack_o,
   output logic [corr_cfg_pkg::ACC_W-1:0]             dat_o
);

   // ----------------------------------------
   // internal connections
   // ----------------------------------------
   corr_types_pkg::slot_t                slot;
   corr_types_pkg::pair_bits_t           bits;
   corr_types_pkg::vis_word_t            rd_data;
   logic                                 active_bank;
   logic                                 rd_en;
   logic [corr_cfg_pkg::BUS_ADR_W-1:0]   rd_adr;

   // slot, bank and clear for each sample
   slot_sequencer u_seq (
      .clk_x         (clk_x),
      .rst           (rst),
      .en_i          (en_i),
      .sw_i          (sw_i),
      .slot_o        (slot),
      .active_bank_o (active_bank)
   );

   // antenna bits for the same sample, one cycle later
   pair_sampler u_sampler (
      .clk_x  (clk_x),
      .rst    (rst),
      .slot_i (slot),
      .re_i   (re_i),
      .im_i   (im_i),
      .bits_o (bits)
   );

   visibility_accum u_accum (
      .clk_x     (clk_x),
      .rst       (rst),
      .slot_i    (slot),
      .bits_i    (bits),
      .rd_en_i   (rd_en),
      .rd_adr_i  (rd_adr),
      .rd_data_o (rd_data)
   );

   vis_bus_port u_bus (
      .clk_x         (clk_x),
      .rst           (rst),
      .cyc_i         (cyc_i),
      .stb_i         (stb_i),
      .we_i          (we_i),
      .adr_i         (adr_i),
      .dat_i         (dat_i),
      .active_bank_i (active_bank),
      .rd_en_o       (rd_en),
      .rd_adr_o      (rd_adr),
      .rd_data_i     (rd_data),
      .ack_o         (ack_o),
      .dat_o         (dat_o)
   );

endmodule

`default_nettype wire

//--- hw/vis_bus_port.sv
`default_nettype none

module vis_bus_port (
   input  wire logic                                  clk_x,
   input  wire logic                                  rst,
   input  wire logic                                  cyc_i,
   input  wire logic                                  stb_i,
   input  wire logic                                  we_i,
   input  wire logic [corr_cfg_pkg::BUS_ADR_W-1:0]    adr_i,
   // write data is dropped, the port is read-only
   input  wire logic [corr_cfg_pkg::ACC_W-1:0]        dat_i,
   input  wire logic                                  active_bank_i,
   output logic                                       rd_en_o,
   output logic [corr_cfg_pkg::BUS_ADR_W-1:0]         rd_adr_o,
   input  wire corr_types_pkg::vis_word_t             rd_data_i,
   output logic                                       ack_o,
   output logic [corr_cfg_pkg::ACC_W-1:0]             dat_o
);

   logic req;
   // sin half selected for the word in flight
   logic sel_sin_q;

   assign req = cyc_i && stb_i;

   // ----------------------------------------
   // read request
   // ----------------------------------------
   // always from the bank not being integrated, so a finished
   // interval can be read while the next one builds up
   assign rd_en_o  = req && !we_i;
   assign rd_adr_o = {~active_bank_i, adr_i[corr_cfg_pkg::SLOT_W-1:0]};

   // every request is acked one cycle later, writes included
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= req;
      end
   end

   always_ff @(posedge clk_x) begin
      if (req) begin
         sel_sin_q <= adr_i[corr_cfg_pkg::BUS_ADR_W-1];
      end
   end

   // memory data lands in the ack cycle
   assign dat_o = sel_sin_q ? rd_data_i.sin : rd_data_i.cos;

endmodule

`default_nettype wire

//--- hw/visibility_accum.sv
`default_nettype none

module visibility_accum (
   input  wire logic                                  clk_x,
   input  wire logic                                  rst,
   input  wire corr_types_pkg::slot_t                 slot_i,
   input  wire corr_types_pkg::pair_bits_t            bits_i,
   // bus read port
   input  wire logic                                  rd_en_i,
   // {bank, slot}
   input  wire logic [corr_cfg_pkg::BUS_ADR_W-1:0]    rd_adr_i,
   output corr_types_pkg::vis_word_t                  rd_data_o
);

   // ----------------------------------------
   // accumulator memories
   // ----------------------------------------
   // two banks of 16 words each, only 12 per bank in use
   logic [corr_cfg_pkg::ACC_W-1:0] cos_mem [2**corr_cfg_pkg::BUS_ADR_W];
   logic [corr_cfg_pkg::ACC_W-1:0] sin_mem [2**corr_cfg_pkg::BUS_ADR_W];

   // stage 1, old value and where it came from
   logic [corr_cfg_pkg::SLOT_W:0]  s1_adr;
   logic                           s1_clear;
   corr_types_pkg::vis_word_t      old_q;
   corr_types_pkg::vis_word_t      base;

   // stage 2, updated value waiting for the write
   logic [corr_cfg_pkg::SLOT_W:0]  s2_adr;
   corr_types_pkg::vis_word_t      sum_q;
   logic                           wr_q;

   // one-bit products
   logic                           cos_hit;
   logic                           sin_hit;

   // ----------------------------------------
   // edge 0, read the old value
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      if (slot_i.en) begin
         s1_adr    <= {slot_i.bank, slot_i.index};
         s1_clear  <= slot_i.clear;
         old_q.cos <= cos_mem[{slot_i.bank, slot_i.index}];
         old_q.sin <= sin_mem[{slot_i.bank, slot_i.index}];
      end
   end

   // ----------------------------------------
   // edge 1, add
   // ----------------------------------------
   // first pass after a switch restarts the count from zero
   assign base = s1_clear ? '0 : old_q;

   // sign agreement counts as a positive product
   assign cos_hit = (bits_i.ar == bits_i.br);
   assign sin_hit = (bits_i.ar == bits_i.bi);

   always_ff @(posedge clk_x) begin
      if (bits_i.go) begin
         s2_adr    <= s1_adr;
         sum_q.cos <= base.cos + {{(corr_cfg_pkg::ACC_W - 1){1'b0}}, cos_hit};
         sum_q.sin <= base.sin + {{(corr_cfg_pkg::ACC_W - 1){1'b0}}, sin_hit};
      end
   end

   // write strobe follows the live bits down the pipe
   always_ff @(posedge clk_x) begin
      if (rst) begin
         wr_q <= 1'b0;
      end else begin
         wr_q <= bits_i.go;
      end
   end

   // ----------------------------------------
   // edge 2, write back
   // ----------------------------------------
   // same address comes round again only 12 enabled cycles later,
   // so no forwarding path is needed
   always_ff @(posedge clk_x) begin
      if (wr_q) begin
         cos_mem[s2_adr] <= sum_q.cos;
         sin_mem[s2_adr] <= sum_q.sin;
      end
   end

   // ----------------------------------------
   // bus read port
   // ----------------------------------------
   // both halves fetched together, the bus picks one
   always_ff @(posedge clk_x) begin
      if (rd_en_i) begin
         rd_data_o.cos <= cos_mem[rd_adr_i];
         rd_data_o.sin <= sin_mem[rd_adr_i];
      end
   end

endmodule

`default_nettype wire

//--- hw/pair_sampler.sv
`default_nettype none

module pair_sampler (
   input  wire logic                                clk_x,
   input  wire logic                                rst,
   input  wire corr_types_pkg::slot_t               slot_i,
   // sign bits, real part
   input  wire logic [corr_cfg_pkg::NUM_ANT-1:0]    re_i,
   // sign bits, imaginary part
   input  wire logic [corr_cfg_pkg::NUM_ANT-1:0]    im_i,
   output corr_types_pkg::pair_bits_t               bits_o
);

   // ----------------------------------------
   // baseline lookup
   // ----------------------------------------
   corr_cfg_pkg::pair_t pair;

   assign pair = corr_cfg_pkg::PAIR_TABLE[slot_i.index];

   logic go_q;
   logic ar_q;
   logic br_q;
   logic bi_q;

   // ----------------------------------------
   // sample register
   // ----------------------------------------
   // one cycle here lines the bits up with the old accumulator value
   // coming out of the memory read
   always_ff @(posedge clk_x) begin
      if (rst) begin
         go_q <= 1'b0;
      end else begin
         go_q <= slot_i.en;
      end
   end

   // only live samples are captured
   always_ff @(posedge clk_x) begin
      if (slot_i.en) begin
         ar_q <= re_i[pair.a];
         br_q <= re_i[pair.b];
         // imaginary part of a is not needed by the one-bit products
         bi_q <= im_i[pair.b];
      end
   end

   assign bits_o = '{
      ar: ar_q,
      br: br_q,
      bi: bi_q,
      go: go_q
   };

endmodule

`default_nettype wire

//--- hw/slot_sequencer.sv
`default_nettype none

module slot_sequencer (
   input  wire logic            clk_x,
   input  wire logic            rst,
   // sample strobe
   input  wire logic            en_i,
   // bank switch request, level or pulse
   input  wire logic            sw_i,
   output corr_types_pkg::slot_t slot_o,
   output logic                 active_bank_o
);

   // ----------------------------------------
   // state
   // ----------------------------------------
   logic [corr_cfg_pkg::SLOT_W-1:0] slot_q;
   logic                            bank_q;
   // switch requested, waiting for the pass boundary
   logic                            pend_q;
   // accumulators restart from zero this pass
   logic                            clear_q;
   logic                            last_slot;
   // enabled edge that closes a pass
   logic                            boundary;

   assign last_slot = (slot_q == corr_cfg_pkg::LAST_SLOT);
   assign boundary  = en_i && last_slot;

   // ----------------------------------------
   // slot counter
   // ----------------------------------------
   // only enabled cycles advance, gaps in en_i are invisible
   always_ff @(posedge clk_x) begin
      if (rst) begin
         slot_q <= '0;
      end else if (en_i) begin
         slot_q <= last_slot ? '0 : slot_q + 1'b1;
      end
   end

   // ----------------------------------------
   // bank switch and clear control
   // ----------------------------------------
   // a request raised mid-pass is held until slot 11 is consumed,
   // so the rest of that pass still lands in the old bank
   always_ff @(posedge clk_x) begin
      if (rst) begin
         bank_q  <= 1'b0;
         pend_q  <= 1'b0;
         // nothing valid in either bank out of reset
         clear_q <= 1'b1;
      end else if (boundary && (sw_i || pend_q)) begin
         bank_q  <= ~bank_q;
         pend_q  <= 1'b0;
         clear_q <= 1'b1;
      end else begin
         if (sw_i) begin
            pend_q <= 1'b1;
         end
         // one full pass with zero base has been written
         if (boundary) begin
            clear_q <= 1'b0;
         end
      end
   end

   // decision for the sample on this edge
   assign slot_o = '{
      bank:  bank_q,
      index: slot_q,
      clear: clear_q,
      en:    en_i
   };

   assign active_bank_o = bank_q;

endmodule

`default_nettype wire

//--- hw/corr_types_pkg.sv
`default_nettype none

package corr_types_pkg;

   // ----------------------------------------
   // sequencer decision for one sample
   // ----------------------------------------
   typedef struct packed {
      // bank being integrated into
      logic                            bank;
      // baseline slot within the pass
      logic [corr_cfg_pkg::SLOT_W-1:0] index;
      // first pass after a switch, old value taken as zero
      logic                            clear;
      // live sample strobe
      logic                            en;
   } slot_t;

   // ----------------------------------------
   // sampled sign bits of one baseline
   // ----------------------------------------
   typedef struct packed {
      logic ar;
      logic br;
      logic bi;
      // bits belong to a live sample
      logic go;
   } pair_bits_t;

   // ----------------------------------------
   // one visibility, cos and sin counts
   // ----------------------------------------
   typedef struct packed {
      logic [corr_cfg_pkg::ACC_W-1:0] cos;
      logic [corr_cfg_pkg::ACC_W-1:0] sin;
   } vis_word_t;

endpackage

`default_nettype wire

//--- hw/corr_cfg_pkg.sv
`default_nettype none

package corr_cfg_pkg;

   // ----------------------------------------
   // array geometry and accumulator sizing
   // ----------------------------------------
   // sign-bit inputs, one real and one imaginary bit each
   localparam int NUM_ANT   = 24;
   // baselines visited per pass
   localparam int NUM_SLOTS = 12;
   localparam int SLOT_W    = 4;
   localparam int ANT_W     = 5;
   // accumulator width, also the bus data width
   localparam int ACC_W     = 32;
   // bus address: bit 4 picks sin over cos, bits 3:0 pick the slot
   localparam int BUS_ADR_W = 5;

   // slot at which a pass wraps and a bank switch may land
   localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_SLOTS - 1);

   // one baseline, a is the real-only side of the product
   typedef struct packed {
      logic [ANT_W-1:0] a;
      logic [ANT_W-1:0] b;
   } pair_t;

   // baseline per slot, walked in order once per pass
   localparam pair_t PAIR_TABLE [NUM_SLOTS] = '{
      '{a: 5'd0,  b: 5'd1},
      '{a: 5'd0,  b: 5'd2},
      '{a: 5'd1,  b: 5'd2},
      '{a: 5'd3,  b: 5'd4},
      '{a: 5'd5,  b: 5'd8},
      '{a: 5'd6,  b: 5'd9},
      '{a: 5'd7,  b: 5'd10},
      '{a: 5'd11, b: 5'd12},
      '{a: 5'd13, b: 5'd17},
      '{a: 5'd14, b: 5'd20},
      '{a: 5'd15, b: 5'd22},
      '{a: 5'd16, b: 5'd23}
   };

endpackage

`default_nettype wire
